//--- common/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

   // -------------------------------------------------------------------------
   // FIFO geometry
   // -------------------------------------------------------------------------
   localparam int FIFO_DEPTH = 16;                  // Entries in the external RAM
   localparam int ADDR_W     = 4;                   // RAM address bits
   localparam int LEVEL_W    = 5;                   // Holds 0 up to FIFO_DEPTH

   // -------------------------------------------------------------------------
   // Status thresholds
   // -------------------------------------------------------------------------
   localparam int AFULL_LEVEL  = 14;                // afull at or above this
   localparam int AEMPTY_LEVEL = 2;                 // aempty at or below this

   // Address into the RAM, wraps at FIFO_DEPTH
   typedef logic [ADDR_W-1:0] addr_t;

   // Occupancy, one more bit than the address so a full FIFO fits
   typedef logic [LEVEL_W-1:0] level_t;

endpackage

`default_nettype wire

//--- common/fifo_req_if.sv
`default_nettype none

// Acceptance from the two request ports and registered status back to them
interface fifo_req_if;

   logic wr_acc;                                    // Write taken this cycle
   logic rd_acc;                                    // Read taken this cycle
   logic full;                                      // Registered, from fifo_level
   logic empty;                                     // Registered, from fifo_level

   // Write side decides on its own request against full
   modport wr_mp (
      output wr_acc,
      input  full
   );

   // Read side mirrors it against empty
   modport rd_mp (
      output rd_acc,
      input  empty
   );

   // Level tracker counts accepted requests and owns the status
   modport lvl_mp (
      input  wr_acc,
      input  rd_acc,
      output full,
      output empty
   );

endinterface

`default_nettype wire

//--- hw/fifo_wr_port.sv
`default_nettype none

module fifo_wr_port (
   input  logic            pos_clk,
   input  logic            aresetn,
   input  logic            we_i,
   fifo_req_if.wr_mp       req,
   output logic            memwe_o,
   output fifo_pkg::addr_t memwaddr_o,
   output logic            wack_o,
   output logic            overflow_o
);

   logic wr_acc;

   // -------------------------------------------------------------------------
   // Acceptance, same cycle as the request
   // -------------------------------------------------------------------------
   // A write into a full FIFO is dropped here and only reported
   assign wr_acc     = we_i & ~req.full;
   assign req.wr_acc = wr_acc;
   assign memwe_o    = wr_acc;                      // RAM write strobe

   // -------------------------------------------------------------------------
   // Write address
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         memwaddr_o <= '0;
      end else if (wr_acc) begin
         if (memwaddr_o == fifo_pkg::addr_t'(fifo_pkg::FIFO_DEPTH - 1)) begin
            memwaddr_o <= '0;                       // Wrap at depth
         end else begin
            memwaddr_o <= memwaddr_o + 1'b1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // Acknowledge and overflow strobes
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o     <= 1'b0;
         overflow_o <= 1'b0;
      end else begin
         wack_o     <= wr_acc;                      // One cycle after acceptance
         overflow_o <= we_i & req.full;             // Refused write
      end
   end

   // Full is only reported after a write this port passed to the RAM
   a_full_after_write : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      $rose(req.full) |-> $past(memwe_o)
   );

endmodule

`default_nettype wire

//--- hw/fifo_rd_port.sv
`default_nettype none

module fifo_rd_port (
   input  logic            pos_clk,
   input  logic            aresetn,
   input  logic            re_i,
   fifo_req_if.rd_mp       req,
   output logic            memre_o,
   output fifo_pkg::addr_t memraddr_o,
   output logic            dvld_o,
   output logic            underflow_o
);

   logic rd_acc;

   // -------------------------------------------------------------------------
   // Acceptance, same cycle as the request
   // -------------------------------------------------------------------------
   assign rd_acc     = re_i & ~req.empty;           // Reads stop at empty
   assign req.rd_acc = rd_acc;
   assign memre_o    = rd_acc;

   // -------------------------------------------------------------------------
   // Read address
   // -------------------------------------------------------------------------
   // Holds the address of the next entry to leave the FIFO
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         memraddr_o <= '0;
      end else if (rd_acc) begin
         if (memraddr_o == fifo_pkg::addr_t'(fifo_pkg::FIFO_DEPTH - 1)) begin
            memraddr_o <= '0;
         end else begin
            memraddr_o <= memraddr_o + 1'b1;        // Next entry
         end
      end
   end

   // -------------------------------------------------------------------------
   // Data-valid and underflow strobes
   // -------------------------------------------------------------------------
   // Synchronous RAM returns data one cycle after the read enable
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_o      <= 1'b0;
         underflow_o <= 1'b0;
      end else begin
         dvld_o      <= rd_acc;
         underflow_o <= re_i & req.empty;           // Refused read
      end
   end

   // Empty only returns after a read this port passed to the RAM
   a_empty_after_read : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      $rose(req.empty) |-> $past(memre_o)
   );

endmodule

`default_nettype wire

//--- hw/fifo_level.sv
`default_nettype none

module fifo_level (
   input  logic             pos_clk,
   input  logic             aresetn,
   fifo_req_if.lvl_mp       req,
   output fifo_pkg::level_t level_o,
   output logic             afull_o,
   output logic             aempty_o
);

   fifo_pkg::level_t level_q;                       // Current occupancy
   fifo_pkg::level_t level_nxt;                     // Occupancy after this edge
   logic             full_q;
   logic             empty_q;
   logic             full_nxt;
   logic             empty_nxt;
   logic             afull_nxt;
   logic             aempty_nxt;

   // -------------------------------------------------------------------------
   // Next occupancy
   // -------------------------------------------------------------------------
   // Write and read together leave the count unchanged
   always_comb begin
      case ({req.wr_acc, req.rd_acc})
         2'b10:   level_nxt = level_q + 1'b1;
         2'b01:   level_nxt = level_q - 1'b1;
         default: level_nxt = level_q;
      endcase
   end

   // Flags come from the next count so they line up with level_o
   assign full_nxt   = (level_nxt == fifo_pkg::level_t'(fifo_pkg::FIFO_DEPTH));
   assign empty_nxt  = (level_nxt == '0);
   assign afull_nxt  = (level_nxt >= fifo_pkg::level_t'(fifo_pkg::AFULL_LEVEL));
   assign aempty_nxt = (level_nxt <= fifo_pkg::level_t'(fifo_pkg::AEMPTY_LEVEL));

   // -------------------------------------------------------------------------
   // Registered count and status
   // -------------------------------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_q  <= '0;
         full_q   <= 1'b0;
         empty_q  <= 1'b1;                          // Starts empty
         afull_o  <= 1'b0;
         aempty_o <= 1'b1;
      end else begin
         level_q  <= level_nxt;
         full_q   <= full_nxt;
         empty_q  <= empty_nxt;
         afull_o  <= afull_nxt;
         aempty_o <= aempty_nxt;
      end
   end

   assign level_o   = level_q;
   assign req.full  = full_q;                       // Back to the write port
   assign req.empty = empty_q;                      // Back to the read port

   // -------------------------------------------------------------------------
   // Checks
   // -------------------------------------------------------------------------
   // Holds only if the write port honours full
   a_level_in_range : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      level_q <= fifo_pkg::level_t'(fifo_pkg::FIFO_DEPTH)
   );

   // A read counted on empty would wrap the occupancy
   a_no_read_on_empty : assert property (
      @(posedge pos_clk) disable iff (!aresetn)
      req.empty |-> !req.rd_acc
   );

endmodule

`default_nettype wire

//--- hw/sync_fifo_ctrl.sv
`default_nettype none

module sync_fifo_ctrl (
   input  logic             pos_clk,
   input  logic             aresetn,
   input  logic             we_i,
   input  logic             re_i,
   output logic             full_o,
   output logic             afull_o,
   output logic             empty_o,
   output logic             aempty_o,
   output fifo_pkg::level_t level_o,
   output logic             wack_o,
   output logic             dvld_o,
   output logic             overflow_o,
   output logic             underflow_o,
   output logic             memwe_o,
   output logic             memre_o,
   output fifo_pkg::addr_t  memwaddr_o,
   output fifo_pkg::addr_t  memraddr_o
);

   // Acceptance and status between the ports and the level tracker
   fifo_req_if i_req ();

   // -------------------------------------------------------------------------
   // Request ports
   // -------------------------------------------------------------------------
   fifo_wr_port i_wr_port (
      .pos_clk    (pos_clk),
      .aresetn    (aresetn),
      .we_i       (we_i),
      .req        (i_req),
      .memwe_o    (memwe_o),
      .memwaddr_o (memwaddr_o),
      .wack_o     (wack_o),
      .overflow_o (overflow_o)
   );

   fifo_rd_port i_rd_port (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .re_i        (re_i),
      .req         (i_req),
      .memre_o     (memre_o),
      .memraddr_o  (memraddr_o),
      .dvld_o      (dvld_o),
      .underflow_o (underflow_o)
   );

   // -------------------------------------------------------------------------
   // Level tracker
   // -------------------------------------------------------------------------
   fifo_level i_level (
      .pos_clk  (pos_clk),
      .aresetn  (aresetn),
      .req      (i_req),
      .level_o  (level_o),
      .afull_o  (afull_o),
      .aempty_o (aempty_o)
   );

   assign full_o  = i_req.full;                     // Same registers the ports see
   assign empty_o = i_req.empty;

endmodule

`default_nettype wire

//--- sim/tb_sync_fifo_ctrl.sv
`default_nettype none

module tb_sync_fifo_ctrl;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_HALF = 4;                     // 8 ns period
   localparam int DEPTH    = fifo_pkg::FIFO_DEPTH;

   logic             pos_clk;
   logic             aresetn;
   logic             we_i;
   logic             re_i;
   logic             full_o;
   logic             afull_o;
   logic             empty_o;
   logic             aempty_o;
   fifo_pkg::level_t level_o;
   logic             wack_o;
   logic             dvld_o;
   logic             overflow_o;
   logic             underflow_o;
   logic             memwe_o;
   logic             memre_o;
   fifo_pkg::addr_t  memwaddr_o;
   fifo_pkg::addr_t  memraddr_o;

   // Rows of the stimulus file
   string row_name [$];
   int    row_rep [$];
   int    row_we [$];
   int    row_re [$];
   int    row_lvl [$];
   int    total_reps;
   int    cycle_limit;
   int    cycles;

   // Reference model, what the DUT should show in the current cycle
   int    m_level;
   int    m_waddr;
   int    m_raddr;
   bit    m_wack;
   bit    m_dvld;
   bit    m_ovf;
   bit    m_unf;
   bit    m_acc_w;
   bit    m_acc_r;

   string cur_test;
   int    errors;
   int    tests_run;
   int    tests_failed;
   int    row_start_err;
   int    pend_row;                                 // Row whose end level is still open
   bit    file_ok;

   sync_fifo_ctrl i_sync_fifo_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o),
      .level_o     (level_o),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o),
      .memwe_o     (memwe_o),
      .memre_o     (memre_o),
      .memwaddr_o  (memwaddr_o),
      .memraddr_o  (memraddr_o)
   );

   initial begin
      pos_clk = 1'b0;
      forever #CLK_HALF pos_clk = ~pos_clk;
   end

   // -------------------------------------------------------------------------
   // Stimulus file
   // -------------------------------------------------------------------------
   task automatic read_stim(output bit ok);
      int              fd;
      int              got;
      string           line;
      logic [8*32-1:0] name_v;
      int              f_rep;
      int              f_we;
      int              f_re;
      int              f_lvl;
      ok         = 1'b0;
      total_reps = 0;
      fd         = $fopen("sim/fifo_stim.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
               // Comment and blank lines never give all five fields
               got = $sscanf(line, "%s %d %d %d %d", name_v, f_rep, f_we, f_re, f_lvl);
               if (got == 5 && f_rep > 0) begin
                  row_name.push_back($sformatf("%0s", name_v));
                  row_rep.push_back(f_rep);
                  row_we.push_back(f_we);
                  row_re.push_back(f_re);
                  row_lvl.push_back(f_lvl);
                  total_reps += f_rep;
               end
            end
         end
         $fclose(fd);
         ok = (row_name.size() > 0);
      end
   endtask

   // -------------------------------------------------------------------------
   // Reference model and checks
   // -------------------------------------------------------------------------
   task automatic model_reset();
      m_level = 0;
      m_waddr = 0;
      m_raddr = 0;
      m_wack  = 1'b0;
      m_dvld  = 1'b0;
      m_ovf   = 1'b0;
      m_unf   = 1'b0;
   endtask

   task automatic check_val(input string what, input int exp_v, input int act_v);
      if (exp_v != act_v) begin
         $display("CHECK FAILED %0s %0s: expected %0d, actual %0d",
                  cur_test, what, exp_v, act_v);
         errors++;
      end
   endtask

   task automatic check_outputs();
      m_acc_w = we_i && (m_level != DEPTH);         // Writes stop at full
      m_acc_r = re_i && (m_level != 0);             // Reads stop at empty
      check_val("memwe_o", int'(m_acc_w), int'(memwe_o));
      check_val("memre_o", int'(m_acc_r), int'(memre_o));
      check_val("memwaddr_o", m_waddr, int'(memwaddr_o));
      check_val("memraddr_o", m_raddr, int'(memraddr_o));
      check_val("level_o", m_level, int'(level_o));
      check_val("full_o", int'(m_level == DEPTH), int'(full_o));
      check_val("empty_o", int'(m_level == 0), int'(empty_o));
      check_val("afull_o", int'(m_level >= fifo_pkg::AFULL_LEVEL), int'(afull_o));
      check_val("aempty_o", int'(m_level <= fifo_pkg::AEMPTY_LEVEL), int'(aempty_o));
      check_val("wack_o", int'(m_wack), int'(wack_o));
      check_val("dvld_o", int'(m_dvld), int'(dvld_o));
      check_val("overflow_o", int'(m_ovf), int'(overflow_o));
      check_val("underflow_o", int'(m_unf), int'(underflow_o));
   endtask

   // State after the coming rising edge
   task automatic step_model();
      m_wack = m_acc_w;
      m_dvld = m_acc_r;
      m_ovf  = we_i && (m_level == DEPTH);          // Uses the old level
      m_unf  = re_i && (m_level == 0);
      if (m_acc_w) begin
         m_waddr = (m_waddr + 1) % DEPTH;
      end
      if (m_acc_r) begin
         m_raddr = (m_raddr + 1) % DEPTH;
      end
      m_level = m_level + int'(m_acc_w) - int'(m_acc_r);
   endtask

   task automatic report_test(input string name, input int first_err);
      tests_run++;
      if (errors == first_err) begin
         $display("PASS  %0s", name);
      end else begin
         tests_failed++;
         $display("FAIL  %0s (%0d errors)", name, errors - first_err);
      end
   endtask

   // Level of the previous row is visible just after the edge
   task automatic finish_row();
      if (pend_row >= 0) begin
         cur_test = row_name[pend_row];
         check_val("level_o at end of row", row_lvl[pend_row], int'(level_o));
         report_test(cur_test, row_start_err);
         row_start_err = errors;
         pend_row      = -1;
      end
   endtask

   // -------------------------------------------------------------------------
   // Sequences
   // -------------------------------------------------------------------------
   task automatic run_reset();
      model_reset();
      cur_test      = "reset";
      row_start_err = errors;
      repeat (2) @(posedge pos_clk);
      @(negedge pos_clk);
      check_outputs();
      report_test(cur_test, row_start_err);
      @(posedge pos_clk);                           // Third edge in reset
      #1 aresetn = 1'b1;
      row_start_err = errors;
   endtask

   task automatic run_rows();
      int r;
      int n;
      pend_row = -1;
      for (r = 0; r < row_name.size(); r++) begin
         for (n = 0; n < row_rep[r]; n++) begin
            @(posedge pos_clk);
            #1;
            finish_row();
            cur_test = row_name[r];
            we_i     = (row_we[r] != 0);
            re_i     = (row_re[r] != 0);
            @(negedge pos_clk);                     // Outputs settled
            check_outputs();
            step_model();
         end
         pend_row = r;
      end
      @(posedge pos_clk);
      #1;
      finish_row();
      we_i = 1'b0;
      re_i = 1'b0;
   endtask

   initial begin : stimulus
      we_i    = 1'b0;
      re_i    = 1'b0;
      aresetn = 1'b0;
      read_stim(file_ok);
      if (!file_ok) begin
         $display("Stimulus file sim/fifo_stim.txt could not be read or holds no rows");
         $display("CHECKS FAILED");
         $finish;
      end else begin
         cycle_limit = total_reps + 50;
         run_reset();
         run_rows();
         $display("Summary: %0d tests, %0d failed, %0d check errors",
                  tests_run, tests_failed, errors);
         if (errors == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
         end else begin
            $display("CHECKS FAILED");
         end
         $finish;
      end
   end

   // Limit is zero until the file has been read
   initial begin : watchdog
      while (cycle_limit == 0 || cycles < cycle_limit) begin
         @(posedge pos_clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/fifo_stim.txt
# name  repeat  we  re  expected_level
# Each row is held for repeat cycles, level is checked after its last cycle

# Idle after reset
idle_after_reset      2   0  0   0

# Filling, aempty clears above 2, afull at 14, full at 16
fill_to_aempty        2   1  0   2
fill_past_aempty      1   1  0   3
fill_to_13           10   1  0  13
fill_to_afull         1   1  0  14
fill_to_full          2   1  0  16

# Writes into a full FIFO
overflow              3   1  0  16
idle_full             2   0  0  16

# Full, the read wins and the write is refused
full_rw_read_wins     1   1  1  15

# Draining, read address wraps after 15
drain_to_aempty      13   0  1   2
drain_to_empty        2   0  1   0

# Reads from an empty FIFO
underflow             2   0  1   0

# Empty, the write wins and the read is refused
empty_rw_write_wins   1   1  1   1

# Both requests on a partly filled FIFO
fill_partial          4   1  0   5
simul_steady          8   1  1   5
drain_partial         3   0  1   2
simul_low             6   1  1   2
fill_again           12   1  0  14
simul_high            5   1  1  14

# Back to full and through it
fill_top              2   1  0  16
full_rw_again         1   1  1  15
simul_after_full      4   1  1  15
drain_all            15   0  1   0

# Single entries in and out
write_one             1   1  0   1
read_one              1   0  1   0
write_one_b           1   1  0   1
read_one_b            1   0  1   0
underflow_again       1   0  1   0
idle_end              3   0  0   0

//--- sync_fifo_ctrl.f
common/fifo_pkg.sv
common/fifo_req_if.sv
hw/fifo_wr_port.sv
hw/fifo_rd_port.sv
hw/fifo_level.sv
hw/sync_fifo_ctrl.sv
sim/tb_sync_fifo_ctrl.sv

//--- Makefile
# Verilator build and run of the sync_fifo_ctrl testbench

TB  := tb_sync_fifo_ctrl
LOG := sim.log

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert -j 0 -f sync_fifo_ctrl.f --top-module $(TB) -Mdir obj_dir
	./obj_dir/V$(TB) | tee $(LOG)
	@grep -q "^ALL CHECKS PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	verilator --lint-only --timing -Wall -f sync_fifo_ctrl.f --top-module sync_fifo_ctrl

clean:
	rm -rf obj_dir $(LOG)
